// ==== hw/ldpc_enc_pkg.sv ====
// shared widths, size limits and strobe type for the block encoder, referenced by scoped names
package ldpc_enc_pkg;

  //------------------------------------------------------------
  // sizes
  //------------------------------------------------------------

  // default data word width, top level parameter Z starts here
  localparam int cZ = 8;

  // parity row storage depth
  localparam int cMAX_ROWS = 16;

  // input buffer depth in words
  localparam int cMAX_CYCLES = 64;

  //------------------------------------------------------------
  // types
  //------------------------------------------------------------

  // one data or parity word
  typedef logic [cZ-1:0] word_t;

  // parity row index
  // as a setting, 0 stands for 16 rows
  typedef logic [3:0] row_t;

  // data word index inside a block
  // as a setting, 0 stands for 64 words
  typedef logic [5:0] cycle_idx_t;

  // frame strobes of the parity phase
  typedef struct packed {
    logic sof;
    logic eof;
  } strb_t;

endpackage

// ==== hw/ldpc_enc_ctrl_if.sv ====
// controller to parity accumulator link, ctrl modport for the FSM side, acc modport for the rows
`timescale 1ns/1ps

interface ldpc_enc_ctrl_if;

  // data phase, from controller
  logic                     cycle_read;
  ldpc_enc_pkg::cycle_idx_t cycle_idx;
  logic                     cycle_first;
  ldpc_enc_pkg::row_t       used_row;

  // parity phase, from controller
  logic                     p_read;
  ldpc_enc_pkg::strb_t      p_strb;
  ldpc_enc_pkg::row_t       p_row_idx;

  // pending flags, from accumulator
  logic                     p_busy;
  logic                     p_read_busy;

  modport ctrl (output cycle_read, cycle_idx, cycle_first, used_row,
                output p_read, p_strb, p_row_idx,
                input  p_busy, p_read_busy);

  modport acc  (input  cycle_read, cycle_idx, cycle_first, used_row,
                input  p_read, p_strb, p_row_idx,
                output p_busy, p_read_busy);

endinterface

// ==== hw/ldpc_enc_cfg_regs.sv ====
// host settings for row count and word count, shadowed so they only change between blocks
`timescale 1ns/1ps

module ldpc_enc_cfg_regs (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     cfg_write,
  input  logic                     cfg_addr,
  input  ldpc_enc_pkg::cycle_idx_t cfg_data,
  input  logic                     idle,
  output ldpc_enc_pkg::row_t       used_row,
  output ldpc_enc_pkg::cycle_idx_t cycle_max_num
);

  // host side copies
  ldpc_enc_pkg::row_t       shadow_row;
  ldpc_enc_pkg::cycle_idx_t shadow_cycle;

  //------------------------------------------------------------
  // shadow registers
  //------------------------------------------------------------

  // addr 0 row count, addr 1 word count
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      shadow_row   <= '0;
      shadow_cycle <= '0;
    end else if (cfg_write) begin
      if (cfg_addr) begin
        shadow_cycle <= cfg_data;
      end else begin
        // row count only needs the low bits
        shadow_row <= cfg_data[3:0];
      end
    end
  end

  //------------------------------------------------------------
  // active registers
  //------------------------------------------------------------

  // follow shadow only while the FSM waits for a block
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      used_row      <= '0;
      cycle_max_num <= '0;
    end else if (idle) begin
      used_row      <= shadow_row;
      cycle_max_num <= shadow_cycle;
    end
  end

endmodule

// ==== hw/ldpc_enc_in_buf.sv ====
// input word buffer, host fills one block, the controller reads it back by word index
`timescale 1ns/1ps

module ldpc_enc_in_buf #(
  parameter int Z = ldpc_enc_pkg::cZ
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     wr,
  input  logic [Z-1:0]             wr_data,
  input  ldpc_enc_pkg::cycle_idx_t cycle_max_num,
  input  logic                     cycle_read,
  input  ldpc_enc_pkg::cycle_idx_t cycle_idx,
  input  logic                     buf_release,
  output logic                     buf_full,
  output logic [Z-1:0]             rd_data
);

  // block storage
  logic [Z-1:0] mem [ldpc_enc_pkg::cMAX_CYCLES];

  ldpc_enc_pkg::cycle_idx_t wr_ptr;
  logic                     wr_ena;
  logic                     wr_last;

  // writes dropped once the block is complete
  assign wr_ena  = wr & ~buf_full;
  // setting 0 wraps to 63, i.e. 64 words
  assign wr_last = (wr_ptr == cycle_max_num - 1'b1);

  //------------------------------------------------------------
  // write side
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr   <= '0;
      buf_full <= 1'b0;
    end else if (buf_release) begin
      // block consumed, open for the next one
      wr_ptr   <= '0;
      buf_full <= 1'b0;
    end else if (wr_ena) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (wr_last) begin
        buf_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (wr_ena) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  //------------------------------------------------------------
  // read side
  //------------------------------------------------------------

  // one cycle read latency
  always_ff @(posedge iclk) begin
    if (cycle_read) begin
      rd_data <= mem[cycle_idx];
    end
  end

endmodule

// ==== hw/ldpc_enc_ctrl.sv ====
// encoder main FSM, sequences the data phase and the parity readout of each block
`timescale 1ns/1ps

module ldpc_enc_ctrl (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     ibuf_full,
  input  ldpc_enc_pkg::row_t       used_row,
  input  ldpc_enc_pkg::cycle_idx_t cycle_max_num,
  output logic                     idle,
  output logic                     buf_release,
  ldpc_enc_ctrl_if.ctrl            enc_if
);

  typedef enum logic [2:0] {
    cRESET_STATE,
    cWAIT_STATE,
    cINIT_STATE,
    cDATA_STATE,
    cWAIT_DATA_STATE,
    cDO_P_STATE,
    cWAIT_DO_P_STATE,
    cDONE_STATE
  } state_t;

  state_t state;

  // word counter with registered terminal flag
  struct packed {
    logic                     done;
    logic                     first;
    ldpc_enc_pkg::cycle_idx_t value;
  } cycle_cnt;

  // row counter, zero marks the first parity read
  struct packed {
    logic               done;
    logic               zero;
    ldpc_enc_pkg::row_t value;
  } row_cnt;

  ldpc_enc_pkg::cycle_idx_t used_cycle_m2;
  ldpc_enc_pkg::row_t       used_row_m1;
  ldpc_enc_pkg::row_t       row_nxt;

  assign row_nxt = row_cnt.value + 1'b1;

  //------------------------------------------------------------
  // FSM
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cRESET_STATE;
    end else begin
      case (state)
        cRESET_STATE     : state <= cWAIT_STATE;
        cWAIT_STATE      : state <= ibuf_full         ? cINIT_STATE      : cWAIT_STATE;
        cINIT_STATE      : state <= cDATA_STATE;
        // one buffer read per cycle
        cDATA_STATE      : state <= cycle_cnt.done    ? cWAIT_DATA_STATE : cDATA_STATE;
        cWAIT_DATA_STATE : state <= !enc_if.p_busy    ? cDO_P_STATE      : cWAIT_DATA_STATE;
        // one row read per cycle
        cDO_P_STATE      : state <= row_cnt.done      ? cWAIT_DO_P_STATE : cDO_P_STATE;
        cWAIT_DO_P_STATE : state <= !enc_if.p_read_busy ? cDONE_STATE    : cWAIT_DO_P_STATE;
        cDONE_STATE      : state <= cWAIT_STATE;
      endcase
    end
  end

  // counters
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cycle_cnt     <= '0;
      row_cnt       <= '0;
      used_cycle_m2 <= '0;
      used_row_m1   <= '0;
    end else begin
      case (state)
        cINIT_STATE : begin
          cycle_cnt       <= '0;
          cycle_cnt.first <= 1'b1;
          row_cnt         <= '0;
          row_cnt.zero    <= 1'b1;
          // single row block ends on its first read
          row_cnt.done    <= (used_row == 4'd1);
          used_row_m1     <= used_row - 1'b1;
          used_cycle_m2   <= cycle_max_num - 2'd2;
        end
        cDATA_STATE : begin
          cycle_cnt.value <= cycle_cnt.value + 1'b1;
          cycle_cnt.done  <= (cycle_cnt.value == used_cycle_m2);
          cycle_cnt.first <= 1'b0;
        end
        cDO_P_STATE : begin
          row_cnt.value <= row_nxt;
          row_cnt.done  <= (row_nxt == used_row_m1);
          row_cnt.zero  <= 1'b0;
        end
        default : begin
        end
      endcase
    end
  end

  //------------------------------------------------------------
  // decode
  //------------------------------------------------------------

  assign idle = (state == cWAIT_STATE);

  assign enc_if.cycle_read  = (state == cDATA_STATE);
  assign enc_if.cycle_idx   = cycle_cnt.value;
  assign enc_if.cycle_first = cycle_cnt.first;
  assign enc_if.used_row    = used_row;

  assign enc_if.p_read    = (state == cDO_P_STATE);
  assign enc_if.p_strb    = ldpc_enc_pkg::strb_t'{sof: row_cnt.zero, eof: row_cnt.done};
  assign enc_if.p_row_idx = row_cnt.value;

  // all data words already accumulated, buffer free
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      buf_release <= 1'b0;
    end else begin
      buf_release <= (state == cDO_P_STATE) & row_cnt.zero;
    end
  end

endmodule

// ==== hw/ldpc_enc_parity_acc.sv ====
// parity row store, two-row accumulation of data words and IRA chained readout
`timescale 1ns/1ps

module ldpc_enc_parity_acc #(
  parameter int Z = ldpc_enc_pkg::cZ
) (
  input  logic          iclk,
  input  logic          ireset,
  input  logic [Z-1:0]  rd_data,
  ldpc_enc_ctrl_if.acc  enc_if,
  output logic          valid,
  output logic          sof,
  output logic          eof,
  output logic [Z-1:0]  data
);

  logic [Z-1:0] rows     [ldpc_enc_pkg::cMAX_ROWS];
  logic [Z-1:0] rows_nxt [ldpc_enc_pkg::cMAX_ROWS];

  // read strobe aligned with rd_data
  logic                     rd_val;
  logic                     rd_first;
  ldpc_enc_pkg::cycle_idx_t rd_idx;

  // 1..16, latched at block start
  logic [4:0]         row_num;
  logic [6:0]         idx_a;
  logic [6:0]         idx_b;
  logic [6:0]         mod_a;
  logic [6:0]         mod_b;
  ldpc_enc_pkg::row_t row_a;
  ldpc_enc_pkg::row_t row_b;
  logic [Z-1:0]       word_rot;

  //------------------------------------------------------------
  // data phase
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_val   <= 1'b0;
      rd_first <= 1'b0;
      row_num  <= '0;
    end else begin
      rd_val   <= enc_if.cycle_read;
      rd_first <= enc_if.cycle_read & enc_if.cycle_first;
      if (enc_if.cycle_read & enc_if.cycle_first) begin
        row_num <= {(enc_if.used_row == '0), enc_if.used_row};
      end
    end
  end

  always_ff @(posedge iclk) begin
    rd_idx <= enc_if.cycle_idx;
  end

  // row a gets the word, row b the next row gets it rotated
  assign idx_a    = {1'b0, rd_idx};
  assign idx_b    = idx_a + 7'd1;
  assign mod_a    = idx_a % {2'b00, row_num};
  assign mod_b    = idx_b % {2'b00, row_num};
  assign row_a    = mod_a[3:0];
  assign row_b    = mod_b[3:0];
  assign word_rot = {rd_data[Z-2:0], rd_data[Z-1]};

  // first word of a block starts from cleared rows
  always_comb begin
    for (int i = 0; i < ldpc_enc_pkg::cMAX_ROWS; i++) begin
      rows_nxt[i] = rd_first ? '0 : rows[i];
      if (row_a == ldpc_enc_pkg::row_t'(i)) begin
        rows_nxt[i] = rows_nxt[i] ^ rd_data;
      end
      // one row case lands here too
      if (row_b == ldpc_enc_pkg::row_t'(i)) begin
        rows_nxt[i] = rows_nxt[i] ^ word_rot;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (rd_val) begin
      for (int i = 0; i < ldpc_enc_pkg::cMAX_ROWS; i++) begin
        rows[i] <= rows_nxt[i];
      end
    end
  end

  //------------------------------------------------------------
  // parity phase
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      valid <= 1'b0;
      sof   <= 1'b0;
      eof   <= 1'b0;
    end else begin
      valid <= enc_if.p_read;
      sof   <= enc_if.p_read & enc_if.p_strb.sof;
      eof   <= enc_if.p_read & enc_if.p_strb.eof;
    end
  end

  // running xor, word before row 0 is zero
  always_ff @(posedge iclk) begin
    if (enc_if.p_read) begin
      data <= (enc_if.p_strb.sof ? '0 : data) ^ rows[enc_if.p_row_idx];
    end
  end

  assign enc_if.p_busy      = rd_val;
  assign enc_if.p_read_busy = valid;

endmodule

// ==== hw/ldpc_enc_top.sv ====
// encoder top level, host config and word stream in, parity words with frame flags out
`timescale 1ns/1ps

module ldpc_enc_top #(
  parameter int Z = ldpc_enc_pkg::cZ
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     cfg_write,
  input  logic                     cfg_addr,
  input  ldpc_enc_pkg::cycle_idx_t cfg_data,
  input  logic                     wr,
  input  logic [Z-1:0]             wr_data,
  output logic                     valid,
  output logic                     sof,
  output logic                     eof,
  output logic [Z-1:0]             data
);

  // active settings
  ldpc_enc_pkg::row_t       used_row;
  ldpc_enc_pkg::cycle_idx_t cycle_max_num;

  logic         idle;
  logic         buf_full;
  logic         buf_release;
  logic [Z-1:0] rd_data;

  ldpc_enc_ctrl_if enc_if ();

  //------------------------------------------------------------
  // host side
  //------------------------------------------------------------

  ldpc_enc_cfg_regs u_cfg_regs (
    .iclk          (iclk),
    .ireset        (ireset),
    .cfg_write     (cfg_write),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .idle          (idle),
    .used_row      (used_row),
    .cycle_max_num (cycle_max_num)
  );

  ldpc_enc_in_buf #(.Z(Z)) u_in_buf (
    .iclk          (iclk),
    .ireset        (ireset),
    .wr            (wr),
    .wr_data       (wr_data),
    .cycle_max_num (cycle_max_num),
    .cycle_read    (enc_if.cycle_read),
    .cycle_idx     (enc_if.cycle_idx),
    .buf_release   (buf_release),
    .buf_full      (buf_full),
    .rd_data       (rd_data)
  );

  //------------------------------------------------------------
  // encoder core
  //------------------------------------------------------------

  ldpc_enc_ctrl u_ctrl (
    .iclk          (iclk),
    .ireset        (ireset),
    .ibuf_full     (buf_full),
    .used_row      (used_row),
    .cycle_max_num (cycle_max_num),
    .idle          (idle),
    .buf_release   (buf_release),
    .enc_if        (enc_if.ctrl)
  );

  ldpc_enc_parity_acc #(.Z(Z)) u_parity_acc (
    .iclk    (iclk),
    .ireset  (ireset),
    .rd_data (rd_data),
    .enc_if  (enc_if.acc),
    .valid   (valid),
    .sof     (sof),
    .eof     (eof),
    .data    (data)
  );

endmodule

// ==== verification/ldpc_enc_properties.sv ====
// concurrent checks on the controller to accumulator handshake, bound into the encoder controller
`timescale 1ns/1ps

module ldpc_enc_properties (
  input logic iclk,
  input logic ireset,
  input logic cycle_read,
  input logic p_read,
  input logic p_busy
);

  // data reads and row reads belong to separate phases
  a_no_overlap : assert property (@(posedge iclk) disable iff (ireset)
    !(cycle_read && p_read))
    else $error("cycle_read and p_read high in the same cycle");

  // rows read out only once the last accumulation is done
  a_read_after_acc : assert property (@(posedge iclk) disable iff (ireset)
    !(p_read && p_busy))
    else $error("p_read while an accumulation is pending");

endmodule

bind ldpc_enc_ctrl ldpc_enc_properties u_ldpc_enc_properties (
  .iclk       (iclk),
  .ireset     (ireset),
  .cycle_read (enc_if.cycle_read),
  .p_read     (enc_if.p_read),
  .p_busy     (enc_if.p_busy)
);

// ==== verification/ldpc_enc_tb.sv ====
// self-checking testbench for the block encoder, runs a table of blocks against a parity model
`timescale 1ns/1ps

module ldpc_enc_tb;

  localparam int cNUM_TESTS = 9;
  localparam int cTIMEOUT   = 2000;

  // one table row: block shape, data seed, sequencing flags
  typedef struct packed {
    int rows;
    int words;
    int seed;
    bit early_cfg;
    bit chain;
  } entry_t;

  logic                     iclk;
  logic                     ireset;
  logic                     cfg_write;
  logic                     cfg_addr;
  ldpc_enc_pkg::cycle_idx_t cfg_data;
  logic                     wr;
  ldpc_enc_pkg::word_t      wr_data;
  logic                     valid;
  logic                     sof;
  logic                     eof;
  ldpc_enc_pkg::word_t      data;

  entry_t              tests    [cNUM_TESTS];
  ldpc_enc_pkg::word_t blk_data [cNUM_TESTS][ldpc_enc_pkg::cMAX_CYCLES];
  ldpc_enc_pkg::word_t exp_par  [ldpc_enc_pkg::cMAX_ROWS];

  // output capture
  ldpc_enc_pkg::word_t got_data [$];
  ldpc_enc_pkg::strb_t got_strb [$];
  int                  got_cyc  [$];
  int                  cyc_num   = 0;
  int                  sof_count = 0;
  int                  err_count = 0;

  ldpc_enc_top #(.Z(ldpc_enc_pkg::cZ)) u_ldpc_enc_top (
    .iclk      (iclk),
    .ireset    (ireset),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_data  (cfg_data),
    .wr        (wr),
    .wr_data   (wr_data),
    .valid     (valid),
    .sof       (sof),
    .eof       (eof),
    .data      (data)
  );

  initial iclk = 1'b0;
  always #4 iclk = ~iclk;

  // sample outputs mid-cycle
  always @(negedge iclk) begin
    ldpc_enc_pkg::strb_t s;
    cyc_num = cyc_num + 1;
    if (!ireset && valid) begin
      s.sof = sof;
      s.eof = eof;
      got_data.push_back(data);
      got_strb.push_back(s);
      got_cyc.push_back(cyc_num);
      if (sof) begin
        sof_count = sof_count + 1;
      end
    end
  end

  //------------------------------------------------------------
  // stimulus table and reference model
  //------------------------------------------------------------

  task automatic load_tests();
    tests[0] = '{rows: 4,  words: 8,  seed: 1, early_cfg: 0, chain: 0};
    tests[1] = '{rows: 1,  words: 5,  seed: 2, early_cfg: 0, chain: 0};
    tests[2] = '{rows: 16, words: 64, seed: 3, early_cfg: 0, chain: 0};
    // next settings written while this block runs
    tests[3] = '{rows: 5,  words: 7,  seed: 4, early_cfg: 1, chain: 0};
    tests[4] = '{rows: 3,  words: 10, seed: 5, early_cfg: 0, chain: 0};
    // back to back, same shape
    tests[5] = '{rows: 6,  words: 12, seed: 6, early_cfg: 0, chain: 1};
    tests[6] = '{rows: 6,  words: 12, seed: 7, early_cfg: 0, chain: 1};
    tests[7] = '{rows: 6,  words: 12, seed: 8, early_cfg: 0, chain: 0};
    tests[8] = '{rows: 2,  words: 2,  seed: 9, early_cfg: 0, chain: 0};
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic fill_data();
    logic [31:0] state;
    state = 32'h57f8;
    for (int t = 0; t < cNUM_TESTS; t++) begin
      state = state ^ tests[t].seed;
      for (int j = 0; j < ldpc_enc_pkg::cMAX_CYCLES; j++) begin
        state = lcg_next(state);
        // upper bits of the LCG are the better mixed ones
        blk_data[t][j] = ldpc_enc_pkg::word_t'(state >> 16);
      end
    end
  endtask

  function automatic ldpc_enc_pkg::word_t rotl1(input ldpc_enc_pkg::word_t w);
    return {w[ldpc_enc_pkg::cZ-2:0], w[ldpc_enc_pkg::cZ-1]};
  endfunction

  // two-row accumulation, then chained xor over the rows
  task automatic calc_parity(input int t);
    ldpc_enc_pkg::word_t acc [ldpc_enc_pkg::cMAX_ROWS];
    int r;
    r = tests[t].rows;
    for (int i = 0; i < ldpc_enc_pkg::cMAX_ROWS; i++) begin
      acc[i] = '0;
    end
    for (int j = 0; j < tests[t].words; j++) begin
      acc[j % r]       = acc[j % r] ^ blk_data[t][j];
      acc[(j + 1) % r] = acc[(j + 1) % r] ^ rotl1(blk_data[t][j]);
    end
    exp_par[0] = acc[0];
    for (int i = 1; i < r; i++) begin
      exp_par[i] = exp_par[i-1] ^ acc[i];
    end
  endtask

  //------------------------------------------------------------
  // host side tasks
  //------------------------------------------------------------

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge iclk);
      #1;
    end
  endtask

  // 16 rows and 64 words both encode as 0
  task automatic write_cfg(input int rows, input int words);
    cfg_write = 1'b1;
    cfg_addr  = 1'b0;
    cfg_data  = ldpc_enc_pkg::cycle_idx_t'(rows % 16);
    idle_cycles(1);
    cfg_addr  = 1'b1;
    cfg_data  = ldpc_enc_pkg::cycle_idx_t'(words % 64);
    idle_cycles(1);
    cfg_write = 1'b0;
  endtask

  task automatic write_block(input int t);
    for (int j = 0; j < tests[t].words; j++) begin
      wr      = 1'b1;
      wr_data = blk_data[t][j];
      idle_cycles(1);
    end
    wr = 1'b0;
  endtask

  task automatic wait_sof(input int blocks, input int t, output bit ok);
    int n;
    n = 0;
    while (sof_count <= blocks && n < cTIMEOUT) begin
      idle_cycles(1);
      n++;
    end
    ok = (sof_count > blocks);
    if (!ok) begin
      $display("timeout: test %0d gave no start of frame within %0d cycles", t, cTIMEOUT);
      err_count++;
    end
  endtask

  task automatic wait_words(input int count, input int t, output bit ok);
    int n;
    n = 0;
    while (got_data.size() < count && n < cTIMEOUT) begin
      idle_cycles(1);
      n++;
    end
    ok = (got_data.size() >= count);
    if (!ok) begin
      $display("timeout: test %0d stopped with %0d of %0d output words", t,
               got_data.size(), count);
      err_count++;
    end
  endtask

  //------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------

  task automatic check_word(input string what, input ldpc_enc_pkg::word_t got,
                            input ldpc_enc_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s data %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flags(input string what, input ldpc_enc_pkg::strb_t got,
                             input ldpc_enc_pkg::strb_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s sof/eof %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  //------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------

  initial begin
    bit                  ok;
    int                  base;
    int                  blocks;
    int                  t_err;
    int                  failed;
    int                  rows;
    string               what;
    ldpc_enc_pkg::strb_t exp_s;
    ireset    = 1'b1;
    cfg_write = 1'b0;
    cfg_addr  = 1'b0;
    cfg_data  = '0;
    wr        = 1'b0;
    wr_data   = '0;
    base      = 0;
    blocks    = 0;
    failed    = 0;
    load_tests();
    fill_data();
    repeat (2) @(posedge iclk);
    #1;
    ireset = 1'b0;
    idle_cycles(2);

    for (int t = 0; t < cNUM_TESTS; t++) begin
      t_err = err_count;
      rows  = tests[t].rows;
      calc_parity(t);
      // settings and words may already be in from the previous block
      if (t == 0) begin
        write_cfg(rows, tests[t].words);
        idle_cycles(2);
        write_block(t);
      end else if (!tests[t-1].early_cfg && !tests[t-1].chain) begin
        write_cfg(rows, tests[t].words);
        idle_cycles(2);
        write_block(t);
      end else if (!tests[t-1].chain) begin
        write_block(t);
      end
      // change settings as the block starts, the running block keeps the old ones
      if (tests[t].early_cfg) begin
        write_cfg(tests[t+1].rows, tests[t+1].words);
      end
      wait_sof(blocks, t, ok);
      // buffer already released once sof shows up
      if (ok && tests[t].chain) begin
        write_block(t + 1);
      end
      if (ok) begin
        wait_words(base + rows, t, ok);
      end
      if (ok) begin
        for (int k = 0; k < rows; k++) begin
          what = $sformatf("test %0d word %0d", t, k);
          exp_s.sof = (k == 0);
          exp_s.eof = (k == rows - 1);
          check_word(what, got_data[base + k], exp_par[k]);
          check_flags(what, got_strb[base + k], exp_s);
          if (got_cyc[base + k] != got_cyc[base] + k) begin
            $display("Error at %0t: %s not on a consecutive valid cycle", $time, what);
            err_count++;
          end
        end
      end
      base   = base + rows;
      blocks = blocks + 1;
      // let the FSM get back to wait so new settings go active
      if (!tests[t].chain) begin
        idle_cycles(6);
      end
      if (err_count != t_err) begin
        failed++;
      end
      $display("test %0d: rows %0d words %0d %s", t, rows, tests[t].words,
               (err_count == t_err) ? "ok" : "FAILED");
    end

    // any valid beyond the expected words is a stray one
    idle_cycles(40);
    if (got_data.size() != base) begin
      $display("Error at %0t: %0d output words seen, expected %0d", $time,
               got_data.size(), base);
      err_count++;
    end

    $display("tests %0d, failed %0d, errors %0d", cNUM_TESTS, failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hw/ldpc_enc_pkg.sv
hw/ldpc_enc_ctrl_if.sv
hw/ldpc_enc_cfg_regs.sv
hw/ldpc_enc_in_buf.sv
hw/ldpc_enc_ctrl.sv
hw/ldpc_enc_parity_acc.sv
hw/ldpc_enc_top.sv
verification/ldpc_enc_properties.sv
verification/ldpc_enc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module ldpc_enc_tb -f tb.f -o ldpc_enc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/ldpc_enc_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
